// ==== bench/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

task automatic load_vectors();
    // word, make_ctrl(rs1, rs2, rd, alu_op, alu_src, mem_size, flags), immediate
    add_vector(32'h003100B3, make_ctrl(2, 3, 1, ALU_ADD, SRC_REG, MEM_B, F_WEN), 0);
    add_vector(32'h40628233, make_ctrl(5, 6, 4, ALU_SUB, SRC_REG, MEM_B, F_WEN), 0);
    add_vector(32'h409453B3, make_ctrl(8, 9, 7, ALU_SRA, SRC_REG, MEM_B, F_WEN), 0);
    add_vector(32'h00C5B533, make_ctrl(11, 12, 10, ALU_SLTU, SRC_REG, MEM_B, F_WEN), 0);
    add_vector(32'h40F706BB, make_ctrl(14, 15, 13, ALU_SUB, SRC_REG, MEM_B, F_WEN | F_WORD), 0);
    add_vector(32'h003110BB, make_ctrl(2, 3, 1, ALU_SLL, SRC_REG, MEM_B, F_WEN | F_WORD), 0);
    add_vector(32'hFF030293, make_ctrl(6, 0, 5, ALU_ADD, SRC_IMM, MEM_B, F_WEN), -16);
    add_vector(32'h43F15093, make_ctrl(2, 0, 1, ALU_SRA, SRC_IMM, MEM_B, F_WEN), 63);
    add_vector(32'h02021193, make_ctrl(4, 0, 3, ALU_SLL, SRC_IMM, MEM_B, F_WEN), 32);
    add_vector(32'h7FF3C313, make_ctrl(7, 0, 6, ALU_XOR, SRC_IMM, MEM_B, F_WEN), 2047);
    add_vector(32'h0014841B, make_ctrl(9, 0, 8, ALU_ADD, SRC_IMM, MEM_B, F_WEN | F_WORD), 1);
    add_vector(32'h41F5D51B, make_ctrl(11, 0, 10, ALU_SRA, SRC_IMM, MEM_B, F_WEN | F_WORD), 31);
    // lui with a nonzero rs1 field
    add_vector(32'h123452B7, make_ctrl(0, 0, 5, ALU_ADD, SRC_IMM, MEM_B, F_WEN), 305418240);
    add_vector(32'hFFFFF317, make_ctrl(0, 0, 6, ALU_ADD, SRC_PC_IMM, MEM_B, F_WEN), -4096);
    add_vector(32'h00414083, make_ctrl(2, 0, 1, ALU_ADD, SRC_IMM, MEM_B, F_WEN | F_RD | F_UNS), 4);
    add_vector(32'hFF823183, make_ctrl(4, 0, 3, ALU_ADD, SRC_IMM, MEM_D, F_WEN | F_RD), -8);
    add_vector(32'h00036283, make_ctrl(6, 0, 5, ALU_ADD, SRC_IMM, MEM_W, F_WEN | F_RD | F_UNS), 0);
    add_vector(32'h00951323, make_ctrl(10, 9, 0, ALU_ADD, SRC_IMM, MEM_H, F_WR), 6);
    add_vector(32'hFEB63423, make_ctrl(12, 11, 0, ALU_ADD, SRC_IMM, MEM_D, F_WR), -24);
    add_vector(32'h00209863, make_ctrl(1, 2, 0, ALU_NE, SRC_REG, MEM_B, F_BR), 16);
    add_vector(32'hFE41FEE3, make_ctrl(3, 4, 0, ALU_GEU, SRC_REG, MEM_B, F_BR), -4);
    add_vector(32'h001000EF, make_ctrl(0, 0, 1, ALU_ADD, SRC_PC_FOUR, MEM_B, F_WEN | F_JMP), 2048);
    add_vector(32'hFFFFF0EF, make_ctrl(0, 0, 1, ALU_ADD, SRC_PC_FOUR, MEM_B, F_WEN | F_JMP), -2);
    add_vector(32'h00C280E7,
               make_ctrl(5, 0, 1, ALU_ADD, SRC_PC_FOUR, MEM_B, F_WEN | F_JMP | F_JALR), 12);
    add_vector(32'h00100073, make_ctrl(0, 0, 0, ALU_ADD, SRC_REG, MEM_B, F_EBRK), 0);
    add_vector(32'h0000000F, illegal_ctrl(), 0);  // fence
    add_vector(32'hFFFFFFFF, illegal_ctrl(), 0);
    add_vector(32'h00000073, illegal_ctrl(), 0);  // ecall
    add_vector(32'h00017083, illegal_ctrl(), 0);  // load funct3 111
    add_vector(32'h00114023, illegal_ctrl(), 0);
    add_vector(32'h0020A063, illegal_ctrl(), 0);
    add_vector(32'h000290E7, illegal_ctrl(), 0);
    add_vector(32'h023100B3, illegal_ctrl(), 0);  // mul
    add_vector(32'h403110B3, illegal_ctrl(), 0);
    add_vector(32'h40111093, illegal_ctrl(), 0);  // slli with bad upper bits
    add_vector(32'h003120BB, illegal_ctrl(), 0);
    add_vector(32'h0201109B, illegal_ctrl(), 0);  // slliw with shamt[5] set
    add_vector(32'h0001409B, illegal_ctrl(), 0);
endtask

`endif

// ==== bench/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int XLEN = 64;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_PASSES = 2;

    localparam logic [9:0] F_WEN  = 10'h001;
    localparam logic [9:0] F_WORD = 10'h002;
    localparam logic [9:0] F_BR   = 10'h004;
    localparam logic [9:0] F_JMP  = 10'h008;
    localparam logic [9:0] F_JALR = 10'h010;
    localparam logic [9:0] F_RD   = 10'h020;
    localparam logic [9:0] F_WR   = 10'h040;
    localparam logic [9:0] F_UNS  = 10'h080;
    localparam logic [9:0] F_EBRK = 10'h100;

    typedef struct packed {
        logic [31:0]     word;
        ctrl_t           ctrl;
        logic [XLEN-1:0] imm;
    } vec_t;

    logic            clk = 1'b0;
    logic            rst_n;
    inst_u           inst;
    logic            inst_valid;
    logic            dec_valid;
    ctrl_t           dec_ctrl;
    logic [XLEN-1:0] dec_imm;

    vec_t   vectors[$];
    vec_t   pend;
    logic   pend_valid = 1'b0;  // an item is in flight
    vec_t   last;
    logic   last_valid = 1'b0;  // a result sits in the output register
    integer seed = 32'h44ed_d3db;

    decode_stage #(.XLEN(XLEN)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec_valid  (dec_valid),
        .dec_ctrl   (dec_ctrl),
        .dec_imm    (dec_imm)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ctrl_t make_ctrl(input int rs1, input int rs2, input int rd,
                                        input alu_op_e op, input alu_src_e src,
                                        input mem_size_e size, input logic [9:0] fl);
        ctrl_t c;
        c              = '0;
        c.rs1_addr     = 5'(rs1);
        c.rs2_addr     = 5'(rs2);
        c.rd_addr      = 5'(rd);
        c.alu_op       = op;
        c.alu_src      = src;
        c.mem_size     = size;
        c.reg_wen      = fl[0];
        c.word_op      = fl[1];
        c.branch       = fl[2];
        c.jump         = fl[3];
        c.jalr         = fl[4];
        c.mem_read     = fl[5];
        c.mem_write    = fl[6];
        c.mem_unsigned = fl[7];
        c.ebreak       = fl[8];
        return c;
    endfunction

    function automatic ctrl_t illegal_ctrl();
        ctrl_t c;
        c         = '0;
        c.illegal = 1'b1;
        return c;
    endfunction

    task automatic add_vector(input logic [31:0] word, input ctrl_t c, input int imm);
        vec_t e;
        e.word = word;
        e.ctrl = c;
        e.imm  = XLEN'(imm);  // immediates are sign-extended 32-bit values
        vectors.push_back(e);
    endtask

    `include "decode_vectors.svh"

    task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic verify_output(input vec_t e);
        if (e.ctrl.illegal) begin
            // only the squash is defined for bad words
            expect_equal(64'(dec_ctrl.illegal), 64'd1, $sformatf("illegal of %h", e.word));
            expect_equal(64'({dec_ctrl.reg_wen, dec_ctrl.mem_read, dec_ctrl.mem_write,
                              dec_ctrl.branch, dec_ctrl.jump}), 64'd0,
                         $sformatf("side effects of %h", e.word));
        end else begin
            expect_equal(64'(dec_ctrl), 64'(e.ctrl), $sformatf("ctrl of %h", e.word));
            expect_equal(dec_imm, e.imm, $sformatf("imm of %h", e.word));
        end
    endtask

    // check the item in flight and present the next one
    task automatic drive_cycle(input logic valid, input vec_t e);
        @(posedge clk);
        #1;
        expect_equal(64'(dec_valid), 64'(pend_valid), "dec_valid");
        if (pend_valid) begin
            verify_output(pend);
            last       = pend;
            last_valid = 1'b1;
        end else if (last_valid) begin
            verify_output(last);  // outputs hold through a gap
        end
        inst_valid = valid;
        if (valid) begin
            inst = e.word;
        end else begin
            inst = $random(seed);  // junk the DUT must ignore
        end
        pend_valid = valid;
        pend       = e;
    endtask

    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_equal(64'(dec_valid), 64'd0, "dec_valid after reset");
        expect_equal(64'(dec_ctrl), 64'd0, "dec_ctrl after reset");
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            foreach (vectors[i]) begin
                if (pass > 0 && ($unsigned($random(seed)) % 3) == 0) begin
                    drive_cycle(1'b0, vectors[i]);
                end
                drive_cycle(1'b1, vectors[i]);
            end
        end
        drive_cycle(1'b0, pend);  // last result
        drive_cycle(1'b0, pend);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #1;
        #(CLK_PERIOD * (RESET_CYCLES + 20 * NUM_PASSES * vectors.size()));
        $display("watchdog expired, the run hung before all vectors were applied");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
source/isa_pkg.sv
source/ctrl_pkg.sv
source/opclass_decode.sv
source/alu_ctrl_decode.sv
source/imm_gen.sv
source/decode_stage.sv
bench/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_decode_stage \
    && ./obj_dir/Vtb_decode_stage > sim.log 2>&1
cat sim.log 2>/dev/null
[ -f sim.log ] || { echo "build failed"; exit 1; }
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

// ==== source/alu_ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl_decode (
    input  isa_pkg::inst_u    inst,
    input  logic              use_funct,
    input  logic              is_word,
    input  logic              is_imm,
    output ctrl_pkg::alu_op_e alu_op,
    output logic              word_op,
    output logic              funct_illegal
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       wide_shift;  // 64-bit imm shift where bit 25 is shamt[5]
    logic       hi_zero;
    logic       hi_alt;
    logic       legal;

    assign funct3     = inst.r.funct3;
    assign funct7     = inst.r.funct7;
    assign wide_shift = is_imm && !is_word;

    always_comb begin
        if (wide_shift) begin
            hi_zero = (funct7[6:1] == 6'b000000);
            hi_alt  = (funct7[6:1] == 6'b010000);
        end else begin
            hi_zero = (funct7 == F7_ZERO);
            hi_alt  = (funct7 == F7_ALT);
        end
    end

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                alu_op = (!is_imm && hi_alt) ? ALU_SUB : ALU_ADD;
                legal  = is_imm || hi_zero || hi_alt;  // addi ignores funct7
            end
            F3_SLL: begin
                alu_op = ALU_SLL;
                legal  = hi_zero;
            end
            F3_SRL_SRA: begin
                alu_op = hi_alt ? ALU_SRA : ALU_SRL;
                legal  = hi_zero || hi_alt;
            end
            F3_SLT: begin
                alu_op = ALU_SLT;
                legal  = !is_word && (is_imm || hi_zero);
            end
            F3_SLTU: begin
                alu_op = ALU_SLTU;
                legal  = !is_word && (is_imm || hi_zero);
            end
            F3_XOR: begin
                alu_op = ALU_XOR;
                legal  = !is_word && (is_imm || hi_zero);
            end
            F3_OR: begin
                alu_op = ALU_OR;
                legal  = !is_word && (is_imm || hi_zero);
            end
            F3_AND: begin
                alu_op = ALU_AND;
                legal  = !is_word && (is_imm || hi_zero);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign funct_illegal = use_funct && !legal;
    assign word_op       = is_word;

endmodule

`default_nettype wire

// ==== source/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,   // branch compares
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_PC_FOUR,  // link value for jal / jalr
        SRC_PC_IMM
    } alu_src_e;

    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W,
        MEM_D
    } mem_size_e;

    typedef struct packed {
        isa_pkg::reg_addr_t rs1_addr;
        isa_pkg::reg_addr_t rs2_addr;
        isa_pkg::reg_addr_t rd_addr;
        logic               reg_wen;
        alu_op_e            alu_op;
        alu_src_e           alu_src;
        logic               word_op;
        logic               branch;
        logic               jump;
        logic               jalr;
        logic               mem_read;
        logic               mem_write;
        mem_size_e          mem_size;
        logic               mem_unsigned;
        logic               ebreak;
        logic               illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  isa_pkg::inst_u  inst,
    input  logic            inst_valid,
    output logic            dec_valid,
    output ctrl_pkg::ctrl_t dec_ctrl,
    output logic [XLEN-1:0] dec_imm
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_t           part_ctrl;
    ctrl_t           next_ctrl;
    imm_fmt_e        imm_fmt;
    logic            use_funct;
    logic            is_word;
    logic            is_imm;
    logic            op_illegal;
    alu_op_e         funct_alu_op;
    logic            word_op;
    logic            funct_illegal;
    logic [XLEN-1:0] imm;

    opclass_decode u_opclass (
        .inst       (inst),
        .part_ctrl  (part_ctrl),
        .imm_fmt    (imm_fmt),
        .use_funct  (use_funct),
        .is_word    (is_word),
        .is_imm     (is_imm),
        .op_illegal (op_illegal)
    );

    alu_ctrl_decode u_alu_ctrl (
        .inst          (inst),
        .use_funct     (use_funct),
        .is_word       (is_word),
        .is_imm        (is_imm),
        .alu_op        (funct_alu_op),
        .word_op       (word_op),
        .funct_illegal (funct_illegal)
    );

    imm_gen #(.XLEN(XLEN)) u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    always_comb begin
        next_ctrl = part_ctrl;
        if (use_funct) begin
            next_ctrl.alu_op = funct_alu_op;  // arithmetic groups only
        end
        next_ctrl.word_op = word_op;
        next_ctrl.illegal = op_illegal | funct_illegal;
        if (next_ctrl.illegal) begin
            // no side effects from a bad word
            next_ctrl.reg_wen   = 1'b0;
            next_ctrl.mem_read  = 1'b0;
            next_ctrl.mem_write = 1'b0;
            next_ctrl.branch    = 1'b0;
            next_ctrl.jump      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_ctrl  <= '0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                dec_ctrl <= next_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec_imm <= imm;  // holds otherwise
        end
    end

endmodule

`default_nettype wire

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen #(
    parameter int XLEN = 64
) (
    input  isa_pkg::inst_u    inst,
    input  isa_pkg::imm_fmt_e imm_fmt,
    output logic [XLEN-1:0]   imm
);
    import isa_pkg::*;

    logic [31:0] w;
    logic [31:0] imm32;

    assign w = inst;

    always_comb begin
        case (imm_fmt)
            IMM_I:       imm32 = {{20{w[31]}}, w[31:20]};
            IMM_I_SHIFT: imm32 = {26'b0, w[25:20]};  // shamt
            IMM_S:       imm32 = {{20{w[31]}}, inst.s.imm_hi, inst.s.imm_lo};
            IMM_B:       imm32 = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:       imm32 = {w[31:12], 12'b0};
            IMM_J:       imm32 = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:     imm32 = 32'b0;
        endcase
    end

    // sign taken from bit 31
    assign imm = XLEN'($signed(imm32));

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // overlays rd
        opcode_e    opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } inst_u;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_I_SHIFT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // arithmetic funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

endpackage

`default_nettype wire

// ==== source/opclass_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module opclass_decode (
    input  isa_pkg::inst_u    inst,
    output ctrl_pkg::ctrl_t   part_ctrl,
    output isa_pkg::imm_fmt_e imm_fmt,
    output logic              use_funct,
    output logic              is_word,
    output logic              is_imm,
    output logic              op_illegal
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [2:0] funct3;

    assign funct3 = inst.r.funct3;

    always_comb begin
        part_ctrl         = '0;
        part_ctrl.alu_op  = ALU_ADD;  // address and link arithmetic
        part_ctrl.alu_src = SRC_REG;
        imm_fmt           = IMM_NONE;
        use_funct         = 1'b0;
        is_word           = 1'b0;
        is_imm            = 1'b0;
        op_illegal        = 1'b0;

        case (inst.r.opcode)
            OPC_OP, OPC_OP_32: begin
                part_ctrl.rs1_addr = inst.r.rs1;
                part_ctrl.rs2_addr = inst.r.rs2;
                part_ctrl.rd_addr  = inst.r.rd;
                part_ctrl.reg_wen  = 1'b1;
                use_funct          = 1'b1;
                is_word            = (inst.r.opcode == OPC_OP_32);
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                part_ctrl.rs1_addr = inst.r.rs1;
                part_ctrl.rd_addr  = inst.r.rd;
                part_ctrl.reg_wen  = 1'b1;
                part_ctrl.alu_src  = SRC_IMM;
                use_funct          = 1'b1;
                is_imm             = 1'b1;
                is_word            = (inst.r.opcode == OPC_OP_IMM_32);
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    imm_fmt = IMM_I_SHIFT;
                end else begin
                    imm_fmt = IMM_I;
                end
            end
            OPC_LOAD: begin
                part_ctrl.rs1_addr     = inst.r.rs1;
                part_ctrl.rd_addr      = inst.r.rd;
                part_ctrl.reg_wen      = 1'b1;
                part_ctrl.alu_src      = SRC_IMM;
                part_ctrl.mem_read     = 1'b1;
                part_ctrl.mem_size     = mem_size_e'(funct3[1:0]);
                part_ctrl.mem_unsigned = funct3[2];
                imm_fmt                = IMM_I;
                op_illegal             = (funct3 == 3'b111);  // no ldu
            end
            OPC_STORE: begin
                part_ctrl.rs1_addr  = inst.s.rs1;
                part_ctrl.rs2_addr  = inst.s.rs2;
                part_ctrl.alu_src   = SRC_IMM;
                part_ctrl.mem_write = 1'b1;
                part_ctrl.mem_size  = mem_size_e'(funct3[1:0]);
                imm_fmt             = IMM_S;
                op_illegal          = funct3[2];
            end
            OPC_BRANCH: begin
                part_ctrl.rs1_addr = inst.s.rs1;
                part_ctrl.rs2_addr = inst.s.rs2;
                part_ctrl.branch   = 1'b1;
                imm_fmt            = IMM_B;
                case (funct3)
                    F3_BEQ:  part_ctrl.alu_op = ALU_EQ;
                    F3_BNE:  part_ctrl.alu_op = ALU_NE;
                    F3_BLT:  part_ctrl.alu_op = ALU_LT;
                    F3_BGE:  part_ctrl.alu_op = ALU_GE;
                    F3_BLTU: part_ctrl.alu_op = ALU_LTU;
                    F3_BGEU: part_ctrl.alu_op = ALU_GEU;
                    default: op_illegal = 1'b1;  // 010, 011
                endcase
            end
            OPC_JAL: begin
                part_ctrl.rd_addr = inst.r.rd;
                part_ctrl.reg_wen = 1'b1;
                part_ctrl.jump    = 1'b1;
                part_ctrl.alu_src = SRC_PC_FOUR;
                imm_fmt           = IMM_J;
            end
            OPC_JALR: begin
                part_ctrl.rs1_addr = inst.r.rs1;
                part_ctrl.rd_addr  = inst.r.rd;
                part_ctrl.reg_wen  = 1'b1;
                part_ctrl.jump     = 1'b1;
                part_ctrl.jalr     = 1'b1;
                part_ctrl.alu_src  = SRC_PC_FOUR;
                imm_fmt            = IMM_I;
                op_illegal         = (funct3 != 3'b000);
            end
            OPC_LUI: begin
                part_ctrl.rd_addr = inst.r.rd;  // x0 + imm
                part_ctrl.reg_wen = 1'b1;
                part_ctrl.alu_src = SRC_IMM;
                imm_fmt           = IMM_U;
            end
            OPC_AUIPC: begin
                part_ctrl.rd_addr = inst.r.rd;
                part_ctrl.reg_wen = 1'b1;
                part_ctrl.alu_src = SRC_PC_IMM;
                imm_fmt           = IMM_U;
            end
            OPC_SYSTEM: begin
                // only the exact ebreak word is supported
                part_ctrl.ebreak = (inst == EBREAK_WORD);
                op_illegal       = (inst != EBREAK_WORD);
            end
            default: begin
                op_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire
